// ==== Bender.yml ====
package:
  name: mips_id_stage

sources:
  - mips_id_pkg.sv
  - id_decoder.sv
  - id_forward.sv
  - id_resolve.sv
  - id_stage.sv
  - target: simulation
    files:
      - tb_id_stage.sv

// ==== id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  mips_id_pkg::inst_u     inst_i,
    output mips_id_pkg::dec_ctrl_t ctrl_o,
    output mips_id_pkg::reg_addr_t rs_addr_o,
    output mips_id_pkg::reg_addr_t rt_addr_o
);
    import mips_id_pkg::*;

    word_t   imm_zext;
    word_t   imm_sext;
    alu_op_t r_aluop;       // R-type op, NOP when funct unknown

    assign imm_zext  = {16'b0, inst_i.i.imm16};
    assign imm_sext  = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
    assign rs_addr_o = inst_i.i.rs;     // addresses go out regardless of enable
    assign rt_addr_o = inst_i.i.rt;

    // SPECIAL words only count with a zero shift amount
    always_comb
    begin
        r_aluop = ALU_NOP;
        if (inst_i.r.shamt == 5'd0)
        begin
            case (inst_i.r.funct)
                FN_ADD:  r_aluop = ALU_ADD;
                FN_SUB:  r_aluop = ALU_SUB;
                FN_SUBU: r_aluop = ALU_SUBU;
                FN_SLT:  r_aluop = ALU_SLT;
                FN_SLTU: r_aluop = ALU_SLTU;
                default: r_aluop = ALU_NOP;
            endcase
        end
    end

    always_comb
    begin
        ctrl_o        = '0;
        ctrl_o.aluop  = ALU_NOP;        // bubble unless decoded below
        ctrl_o.alusel = RES_NOP;
        ctrl_o.waddr  = inst_i.r.rd;
        case (inst_i.j.op)
            OP_ORI:
            begin
                ctrl_o.aluop  = ALU_OR;
                ctrl_o.alusel = RES_LOGIC;
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.imm    = imm_zext;       // logical imm, no sign
                ctrl_o.we     = 1'b1;
                ctrl_o.waddr  = inst_i.i.rt;
            end
            OP_ADDIU:
            begin
                ctrl_o.aluop  = ALU_ADDIU;
                ctrl_o.alusel = RES_ARITH;
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.imm    = imm_sext;
                ctrl_o.we     = 1'b1;
                ctrl_o.waddr  = inst_i.i.rt;
            end
            OP_LW:
            begin
                ctrl_o.aluop  = ALU_LW;
                ctrl_o.alusel = RES_LOAD_STORE;
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.imm    = imm_sext;       // address offset in op2
                ctrl_o.we     = 1'b1;
                ctrl_o.waddr  = inst_i.i.rt;
            end
            OP_SW:
            begin
                ctrl_o.aluop  = ALU_SW;
                ctrl_o.alusel = RES_LOAD_STORE;
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.rt_re  = 1'b1;           // store data
                ctrl_o.imm    = imm_sext;
            end
            OP_BEQ:
            begin
                ctrl_o.aluop  = ALU_BEQ;
                ctrl_o.alusel = RES_JUMP_BRANCH;
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.rt_re  = 1'b1;
                ctrl_o.is_beq = 1'b1;
            end
            OP_J:
            begin
                ctrl_o.aluop  = ALU_J;
                ctrl_o.alusel = RES_JUMP_BRANCH;
                ctrl_o.is_j   = 1'b1;           // no register reads
            end
            OP_SPECIAL:
            begin
                if (r_aluop != ALU_NOP)
                begin
                    ctrl_o.aluop  = r_aluop;
                    ctrl_o.alusel = RES_ARITH;
                    ctrl_o.rs_re  = 1'b1;
                    ctrl_o.rt_re  = 1'b1;
                    ctrl_o.we     = 1'b1;
                end
            end
            default:
            begin
                ctrl_o.aluop = ALU_NOP;         // unknown opcode
            end
        endcase
    end

endmodule

// ==== id_forward.sv ====
`timescale 1ns/1ps

module id_forward (
    input  mips_id_pkg::reg_addr_t rs_addr_i,
    input  mips_id_pkg::reg_addr_t rt_addr_i,
    input  mips_id_pkg::word_t     rs_data_i,
    input  mips_id_pkg::word_t     rt_data_i,
    input  mips_id_pkg::wb_fwd_t   ex_fwd_i,
    input  mips_id_pkg::wb_fwd_t   mem_fwd_i,
    output mips_id_pkg::word_t     rs_val_o,
    output mips_id_pkg::word_t     rt_val_o,
    output logic                   rs_ex_hit_o,
    output logic                   rt_ex_hit_o
);
    import mips_id_pkg::*;

    function automatic logic src_hit(input wb_fwd_t src, input reg_addr_t addr);
        return src.we && (src.waddr == addr);
    endfunction

    // newest writer wins: execute, then memory, then register file
    function automatic word_t fwd_pick(input reg_addr_t addr,
                                       input word_t     rf_data,
                                       input wb_fwd_t   ex_src,
                                       input wb_fwd_t   mem_src);
        word_t val;
        if (src_hit(ex_src, addr))
        begin
            val = ex_src.wdata;
        end
        else if (src_hit(mem_src, addr))
        begin
            val = mem_src.wdata;
        end
        else
        begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs_val_o = fwd_pick(rs_addr_i, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val_o = fwd_pick(rt_addr_i, rt_data_i, ex_fwd_i, mem_fwd_i);

    assign rs_ex_hit_o = src_hit(ex_fwd_i, rs_addr_i);     // feeds load-use check
    assign rt_ex_hit_o = src_hit(ex_fwd_i, rt_addr_i);

endmodule

// ==== id_resolve.sv ====
`timescale 1ns/1ps

module id_resolve (
    input  logic                   clk,
    input  logic                   rst_i,
    input  mips_id_pkg::word_t     pc_i,
    input  mips_id_pkg::inst_u     inst_i,
    input  mips_id_pkg::dec_ctrl_t ctrl_i,
    input  mips_id_pkg::word_t     rs_val_i,
    input  mips_id_pkg::word_t     rt_val_i,
    input  logic                   rs_ex_hit_i,
    input  logic                   rt_ex_hit_i,
    input  mips_id_pkg::alu_op_t   ex_aluop_i,
    output logic                   stall_o,
    output logic                   branch_taken_o,
    output mips_id_pkg::word_t     branch_target_o,
    output mips_id_pkg::id_ex_t    id_ex_o
);
    import mips_id_pkg::*;

    localparam id_ex_t ID_EX_BUBBLE = '{aluop: ALU_NOP, alusel: RES_NOP, default: '0};

    word_t op1;
    word_t op2;
    word_t pc_plus_4;
    word_t beq_target;
    word_t j_target;
    logic  load_in_ex;
    logic  beq_taken;
    logic  branch_req;
    logic  in_delay_q;      // previous instruction was a taken branch

    assign op1 = ctrl_i.rs_re ? rs_val_i : ctrl_i.imm;
    assign op2 = ctrl_i.rt_re ? rt_val_i : ctrl_i.imm;

    // load result not ready until after memory, so hold decode a cycle
    assign load_in_ex = (ex_aluop_i == ALU_LW);
    assign stall_o    = !rst_i && load_in_ex &&
                        ((ctrl_i.rs_re && rs_ex_hit_i) || (ctrl_i.rt_re && rt_ex_hit_i));

    assign pc_plus_4  = pc_i + 32'd4;
    assign beq_target = pc_plus_4 + {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};
    assign j_target   = {pc_plus_4[31:28], inst_i.j.target26, 2'b00};

    assign beq_taken      = ctrl_i.is_beq && (op1 == op2);
    assign branch_req     = beq_taken || ctrl_i.is_j;
    assign branch_taken_o = branch_req && !stall_o && !rst_i;  // operands may be stale

    always_comb
    begin
        if (!branch_taken_o)
        begin
            branch_target_o = '0;
        end
        else if (ctrl_i.is_j)
        begin
            branch_target_o = j_target;
        end
        else
        begin
            branch_target_o = beq_target;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            in_delay_q <= 1'b0;
        end
        else if (!stall_o)
        begin
            in_delay_q <= branch_taken_o;   // held over a stall
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i || stall_o)
        begin
            id_ex_o <= ID_EX_BUBBLE;        // stalled slot goes out empty
        end
        else
        begin
            id_ex_o.aluop         <= ctrl_i.aluop;
            id_ex_o.alusel        <= ctrl_i.alusel;
            id_ex_o.op1           <= op1;
            id_ex_o.op2           <= op2;
            id_ex_o.we            <= ctrl_i.we;
            id_ex_o.waddr         <= ctrl_i.waddr;
            id_ex_o.in_delay_slot <= in_delay_q;
        end
    end

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   rst_i,

    // from fetch
    input  mips_id_pkg::word_t     pc_i,
    input  mips_id_pkg::inst_u     inst_i,

    // register file read ports, data valid same cycle
    input  mips_id_pkg::word_t     rs_data_i,
    input  mips_id_pkg::word_t     rt_data_i,
    output mips_id_pkg::reg_addr_t rs_addr_o,
    output mips_id_pkg::reg_addr_t rt_addr_o,
    output logic                   rs_rd_en_o,
    output logic                   rt_rd_en_o,

    // bypass from later stages
    input  mips_id_pkg::wb_fwd_t   ex_fwd_i,
    input  mips_id_pkg::wb_fwd_t   mem_fwd_i,
    input  mips_id_pkg::alu_op_t   ex_aluop_i,

    output logic                   stall_o,
    output logic                   branch_taken_o,
    output mips_id_pkg::word_t     branch_target_o,
    output mips_id_pkg::id_ex_t    id_ex_o
);
    import mips_id_pkg::*;

    dec_ctrl_t dec_ctrl;
    word_t     rs_val;
    word_t     rt_val;
    logic      rs_ex_hit;
    logic      rt_ex_hit;

    assign rs_rd_en_o = dec_ctrl.rs_re;
    assign rt_rd_en_o = dec_ctrl.rt_re;

    id_decoder id_decoder_i (
        .inst_i    (inst_i),
        .ctrl_o    (dec_ctrl),
        .rs_addr_o (rs_addr_o),
        .rt_addr_o (rt_addr_o)
    );

    id_forward id_forward_i (
        .rs_addr_i   (rs_addr_o),
        .rt_addr_i   (rt_addr_o),
        .rs_data_i   (rs_data_i),
        .rt_data_i   (rt_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .rs_val_o    (rs_val),
        .rt_val_o    (rt_val),
        .rs_ex_hit_o (rs_ex_hit),
        .rt_ex_hit_o (rt_ex_hit)
    );

    id_resolve id_resolve_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .ctrl_i          (dec_ctrl),
        .rs_val_i        (rs_val),
        .rt_val_i        (rt_val),
        .rs_ex_hit_i     (rs_ex_hit),
        .rt_ex_hit_i     (rt_ex_hit),
        .ex_aluop_i      (ex_aluop_i),
        .stall_o         (stall_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .id_ex_o         (id_ex_o)
    );

endmodule

// ==== mips_id_pkg.sv ====
package mips_id_pkg;

    typedef logic [31:0] word_t;        // data or address word
    typedef logic [4:0]  reg_addr_t;    // register number

    // ALU operation codes seen by execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_OR    = 8'b0010_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_ADD   = 8'b0010_0000,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_LW    = 8'b1110_0011,
        ALU_SW    = 8'b1110_1011,
        ALU_BEQ   = 8'b0101_0001,
        ALU_J     = 8'b0100_1111
    } alu_op_t;

    // result class, picks the execute result mux
    typedef enum logic [2:0] {
        RES_NOP         = 3'b000,
        RES_LOGIC       = 3'b001,
        RES_ARITH       = 3'b100,
        RES_JUMP_BRANCH = 3'b110,
        RES_LOAD_STORE  = 3'b111
    } alu_sel_t;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_J       = 6'b000010;

    localparam logic [5:0] FN_ADD  = 6'b100000;    // SPECIAL funct field
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } inst_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } inst_j_t;

    // one instruction word, three field layouts
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        alu_op_t   aluop;
        alu_sel_t  alusel;
        logic      we;          // writes a register
        reg_addr_t waddr;
        logic      rs_re;       // rs read from register file
        logic      rt_re;       // rt read from register file
        word_t     imm;         // extended immediate
        logic      is_beq;
        logic      is_j;
    } dec_ctrl_t;

    // write port of a later stage, used for bypass
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_fwd_t;

    typedef struct packed {
        alu_op_t   aluop;
        alu_sel_t  alusel;
        word_t     op1;
        word_t     op2;
        logic      we;
        reg_addr_t waddr;
        logic      in_delay_slot;
    } id_ex_t;

endpackage

// ==== sim.f ====
mips_id_pkg.sv
id_decoder.sv
id_forward.sv
id_resolve.sv
id_stage.sv
tb_id_stage.sv

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;
    import mips_id_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int TEST_CYCLES = 5 + 11 + 3 + 3 + 4 + 2;   // reset, decode, fwd, stall, branch, flush
    localparam int MARGIN_NS   = 1000;

    localparam logic [5:0] FN_TAB [5]  = '{FN_ADD, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    localparam alu_op_t    ROP_TAB [5] = '{ALU_ADD, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU};

    // everything driven into the stage for one instruction
    typedef struct packed {
        word_t   pc;
        inst_u   inst;
        word_t   rs_d;
        word_t   rt_d;
        wb_fwd_t exf;
        wb_fwd_t memf;
        alu_op_t exop;
    } stim_t;

    typedef struct packed {
        id_ex_t pkt;        // in_delay_slot filled in by step
        logic   rs_re;
        logic   rt_re;
        logic   stall;
        logic   taken;
        word_t  target;
    } exp_t;

    logic      clk = 1'b0;
    logic      rst_i;
    word_t     pc_i;
    inst_u     inst_i;
    word_t     rs_data_i;
    word_t     rt_data_i;
    reg_addr_t rs_addr_o;
    reg_addr_t rt_addr_o;
    logic      rs_rd_en_o;
    logic      rt_rd_en_o;
    wb_fwd_t   ex_fwd_i;
    wb_fwd_t   mem_fwd_i;
    alu_op_t   ex_aluop_i;
    logic      stall_o;
    logic      branch_taken_o;
    word_t     branch_target_o;
    id_ex_t    id_ex_o;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'h164f;
    id_ex_t      pend_pkt = '0;     // packet due after the next edge
    logic        prev_taken = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    id_stage id_stage_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .rs_data_i       (rs_data_i),
        .rt_data_i       (rt_data_i),
        .rs_addr_o       (rs_addr_o),
        .rt_addr_o       (rt_addr_o),
        .rs_rd_en_o      (rs_rd_en_o),
        .rt_rd_en_o      (rt_rd_en_o),
        .ex_fwd_i        (ex_fwd_i),
        .mem_fwd_i       (mem_fwd_i),
        .ex_aluop_i      (ex_aluop_i),
        .stall_o         (stall_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .id_ex_o         (id_ex_o)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int b = 0; b < n; b++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic stim_t random_stim();
        stim_t s;
        s      = '0;
        s.pc   = rand_bits(30) << 2;    // word aligned
        s.inst = rand_bits(32);
        s.rs_d = rand_bits(32);
        s.rt_d = rand_bits(32);
        s.exop = ALU_NOP;
        return s;
    endfunction

    // ADD with distinct rs and rt
    function automatic stim_t add_stim();
        stim_t s;
        s              = random_stim();
        s.inst.r.op    = OP_SPECIAL;
        s.inst.r.shamt = 5'd0;
        s.inst.r.funct = FN_ADD;
        s.inst.r.rt    = s.inst.r.rs ^ 5'd1;
        return s;
    endfunction

    function automatic exp_t r_expect(input stim_t s, input alu_op_t op,
                                      input word_t op1, input word_t op2);
        exp_t e;
        e            = '0;
        e.pkt.aluop  = op;
        e.pkt.alusel = RES_ARITH;
        e.pkt.op1    = op1;
        e.pkt.op2    = op2;
        e.pkt.we     = 1'b1;
        e.pkt.waddr  = s.inst.r.rd;
        e.rs_re      = 1'b1;
        e.rt_re      = 1'b1;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_packet(input id_ex_t exp);
        check("id_ex_o.aluop", id_ex_o.aluop, exp.aluop);
        check("id_ex_o.alusel", id_ex_o.alusel, exp.alusel);
        check("id_ex_o.op1", id_ex_o.op1, exp.op1);
        check("id_ex_o.op2", id_ex_o.op2, exp.op2);
        check("id_ex_o.we", id_ex_o.we, exp.we);
        if (exp.we)
        begin
            check("id_ex_o.waddr", id_ex_o.waddr, exp.waddr);   // don't care without a write
        end
        check("id_ex_o.in_delay_slot", id_ex_o.in_delay_slot, exp.in_delay_slot);
    endtask

    task automatic drive_inputs(input stim_t s);
        pc_i       <= s.pc;
        inst_i     <= s.inst;
        rs_data_i  <= s.rs_d;
        rt_data_i  <= s.rt_d;
        ex_fwd_i   <= s.exf;
        mem_fwd_i  <= s.memf;
        ex_aluop_i <= s.exop;
    endtask

    // one instruction per cycle, packet of the previous one checked here
    task automatic step(input stim_t s, input exp_t e);
        @(posedge clk);
        drive_inputs(s);
        @(negedge clk);
        compare_packet(pend_pkt);
        check("rs_rd_en_o", rs_rd_en_o, e.rs_re);
        check("rt_rd_en_o", rt_rd_en_o, e.rt_re);
        if (e.rs_re)
        begin
            check("rs_addr_o", rs_addr_o, s.inst.i.rs);
        end
        if (e.rt_re)
        begin
            check("rt_addr_o", rt_addr_o, s.inst.i.rt);
        end
        check("stall_o", stall_o, e.stall);
        check("branch_taken_o", branch_taken_o, e.taken);
        if (e.taken)
        begin
            check("branch_target_o", branch_target_o, e.target);
        end
        if (e.stall)
        begin
            pend_pkt = '0;                  // bubble, delay flag held
        end
        else
        begin
            pend_pkt               = e.pkt;
            pend_pkt.in_delay_slot = prev_taken;
            prev_taken             = e.taken;
        end
    endtask

    // a jump and then a load-use hazard sit at the inputs while reset is high
    task automatic reset_sequence();
        stim_t jump;
        stim_t load_use;
        int    c;
        jump           = random_stim();
        jump.inst.j.op = OP_J;
        load_use       = add_stim();
        load_use.exf   = '{we: 1'b1, waddr: load_use.inst.r.rs, wdata: rand_bits(32)};
        load_use.exop  = ALU_LW;
        for (c = 0; c < 5; c++)
        begin
            @(posedge clk);
            if (c < 2)
            begin
                drive_inputs(jump);
            end
            else if (c < 4)
            begin
                drive_inputs(load_use);
            end
            else
            begin
                rst_i <= 1'b0;
                drive_inputs('0);
            end
            @(negedge clk);
            compare_packet('0);
            check("stall_o", stall_o, 1'b0);
            check("branch_taken_o", branch_taken_o, 1'b0);
        end
    endtask

    task automatic decode_all();
        stim_t s;
        exp_t  e;
        int    k;
        for (k = 0; k < 11; k++)
        begin
            s            = random_stim();
            e            = '0;
            e.pkt.op1    = s.rs_d;
            e.pkt.op2    = sext16(s.inst.i.imm16);
            e.pkt.we     = 1'b1;
            e.pkt.waddr  = s.inst.i.rt;
            e.pkt.alusel = RES_LOAD_STORE;
            e.rs_re      = 1'b1;
            case (k)
                0:
                begin
                    s.inst.i.op  = OP_ORI;
                    e.pkt.aluop  = ALU_OR;
                    e.pkt.alusel = RES_LOGIC;
                    e.pkt.op2    = {16'b0, s.inst.i.imm16};     // zero extended
                end
                1:
                begin
                    s.inst.i.op  = OP_ADDIU;
                    e.pkt.aluop  = ALU_ADDIU;
                    e.pkt.alusel = RES_ARITH;
                end
                2:
                begin
                    s.inst.i.op = OP_LW;
                    e.pkt.aluop = ALU_LW;
                end
                3:
                begin
                    s.inst.i.op = OP_SW;
                    e.pkt.aluop = ALU_SW;
                    e.pkt.op2   = s.rt_d;
                    e.pkt.we    = 1'b0;
                    e.rt_re     = 1'b1;
                end
                4:
                begin
                    s.inst.i.op  = OP_BEQ;
                    e            = r_expect(s, ALU_BEQ, s.rs_d, s.rt_d);
                    e.pkt.alusel = RES_JUMP_BRANCH;
                    e.pkt.we     = 1'b0;
                    e.taken      = (s.rs_d == s.rt_d);
                    e.target     = s.pc + 32'd4 + (sext16(s.inst.i.imm16) << 2);
                end
                5:
                begin
                    s.inst.j.op  = OP_J;
                    e            = '0;                  // J reads nothing and has no immediate
                    e.pkt.aluop  = ALU_J;
                    e.pkt.alusel = RES_JUMP_BRANCH;
                    e.taken      = 1'b1;
                    e.target     = {s.pc[31:28] + 4'(s.pc[27:0] > 28'hffffffb),
                                    s.inst.j.target26, 2'b00};
                end
                default:
                begin
                    s.inst.r.op    = OP_SPECIAL;
                    s.inst.r.shamt = 5'd0;
                    s.inst.r.funct = FN_TAB[k - 6];
                    e              = r_expect(s, ROP_TAB[k - 6], s.rs_d, s.rt_d);
                end
            endcase
            step(s, e);
        end
    endtask

    task automatic forward_priority();
        stim_t s;
        exp_t  e;
        word_t ex_val;
        word_t mem_val;
        int    m;
        s       = add_stim();
        ex_val  = rand_bits(32);
        mem_val = rand_bits(32);
        for (m = 0; m < 3; m++)     // execute only, memory only, both
        begin
            s.exf  = '{we: (m != 1), waddr: s.inst.r.rs, wdata: ex_val};
            s.memf = '{we: (m != 0), waddr: s.inst.r.rs, wdata: mem_val};
            e      = r_expect(s, ALU_ADD, (m == 1) ? mem_val : ex_val, s.rt_d);
            step(s, e);
        end
    endtask

    task automatic load_use_stall();
        stim_t s;
        exp_t  e;
        word_t load_val;
        s        = add_stim();
        load_val = rand_bits(32);
        s.exf    = '{we: 1'b1, waddr: s.inst.r.rt, wdata: rand_bits(32)};
        s.exop   = ALU_LW;
        e        = r_expect(s, ALU_ADD, s.rs_d, s.rt_d);
        e.stall  = 1'b1;
        step(s, e);
        // load now in memory, held ADD picks it up
        s.exf  = '0;
        s.exop = ALU_NOP;
        s.memf = '{we: 1'b1, waddr: s.inst.r.rt, wdata: load_val};
        e      = r_expect(s, ALU_ADD, s.rs_d, load_val);
        step(s, e);
        s.inst.i.op  = OP_ORI;         // only rs is read
        s.memf       = '0;
        s.exf        = '{we: 1'b1, waddr: s.inst.i.rt, wdata: rand_bits(32)};
        s.exop       = ALU_LW;
        e            = '0;
        e.pkt.aluop  = ALU_OR;
        e.pkt.alusel = RES_LOGIC;
        e.pkt.op1    = s.rs_d;
        e.pkt.op2    = {16'b0, s.inst.i.imm16};
        e.pkt.we     = 1'b1;
        e.pkt.waddr  = s.inst.i.rt;
        e.rs_re      = 1'b1;
        step(s, e);
    endtask

    task automatic branch_and_jump();
        stim_t s;
        exp_t  e;
        word_t pc4;
        s            = random_stim();
        s.inst.i.op  = OP_BEQ;
        s.rt_d       = s.rs_d;
        pc4          = s.pc + 32'd4;
        e            = r_expect(s, ALU_BEQ, s.rs_d, s.rs_d);
        e.pkt.alusel = RES_JUMP_BRANCH;
        e.pkt.we     = 1'b0;
        e.taken      = 1'b1;
        e.target     = pc4 + (sext16(s.inst.i.imm16) << 2);
        step(s, e);
        s.rt_d    = ~s.rs_d;        // same BEQ, now unequal and in the slot
        e.pkt.op2 = s.rt_d;
        e.taken   = 1'b0;
        step(s, e);
        s            = random_stim();
        s.inst.j.op  = OP_J;
        pc4          = s.pc + 32'd4;
        e            = '0;
        e.pkt.aluop  = ALU_J;
        e.pkt.alusel = RES_JUMP_BRANCH;
        e.taken      = 1'b1;
        e.target     = {pc4[31:28], s.inst.j.target26, 2'b00};
        step(s, e);
        step('0, '0);               // slot of the jump
    endtask

    initial
    begin
        rst_i      = 1'b1;
        pc_i       = '0;
        inst_i     = '0;
        rs_data_i  = '0;
        rt_data_i  = '0;
        ex_fwd_i   = '0;
        mem_fwd_i  = '0;
        ex_aluop_i = ALU_NOP;
        reset_sequence();
        decode_all();
        forward_priority();
        load_use_stall();
        branch_and_jump();
        step('0, '0);               // drains the last packet
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial
    begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule
